/* axil_cycle_reader.sv */
// AXI-Lite read channel of the benchmark controller.
// Returns the engines' 64-bit cycle counts one 32-bit half per read,
// alternating lower and upper for each register on its own.
`timescale 1ns/10ps
`default_nettype none

module axil_cycle_reader (
  input  logic                                   user_clk,
  input  logic                                   user_aresetn,
  input  logic [bench_ctrl_pkg::AXIL_ADDR_W-1:0] araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic                                   rvalid,
  output logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] rdata,
  output logic [1:0]                             rresp,
  input  logic                                   rready,
  input  logic [bench_ctrl_pkg::CYCLES_W-1:0]    ddr_exec_cycles,
  input  logic [bench_ctrl_pkg::CYCLES_W-1:0]    dma_exec_cycles
);

  bench_ctrl_pkg::rd_state_e rd_state;

  logic [bench_ctrl_pkg::AXIL_ADDR_W-1:0] ar_shifted;
  logic [bench_ctrl_pkg::REG_IDX_W-1:0]   ar_idx;
  logic [bench_ctrl_pkg::REG_IDX_W-1:0]   rd_idx;    // index of the read in flight
  logic                                   ddr_upper; // next ddr read returns the upper half
  logic                                   dma_upper;

  assign ar_shifted = araddr >> bench_ctrl_pkg::REG_ADDR_SHIFT;
  assign ar_idx     = ar_shifted[bench_ctrl_pkg::REG_IDX_W-1:0];

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      rd_state  <= bench_ctrl_pkg::RD_IDLE;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      ddr_upper <= 1'b0;
      dma_upper <= 1'b0;
    end else begin
      case (rd_state)
        bench_ctrl_pkg::RD_IDLE: begin
          arready <= 1'b1;
          if (arvalid && arready) begin
            arready  <= 1'b0;
            rvalid   <= 1'b1;
            rd_idx   <= ar_idx;
            rd_state <= bench_ctrl_pkg::RD_RESP;
            rresp    <= bench_ctrl_pkg::RESP_OKAY;
            case (ar_idx)
              bench_ctrl_pkg::REG_DDR_CYCLES:
                rdata <= ddr_upper ? ddr_exec_cycles[63:32] : ddr_exec_cycles[31:0];
              bench_ctrl_pkg::REG_DMA_CYCLES:
                rdata <= dma_upper ? dma_exec_cycles[63:32] : dma_exec_cycles[31:0];
              default: begin
                rresp <= bench_ctrl_pkg::RESP_SLVERR;
                rdata <= bench_ctrl_pkg::BAD_READ_DATA;
              end
            endcase
          end
        end
        bench_ctrl_pkg::RD_RESP: begin
          if (rvalid && rready) begin
            rvalid   <= 1'b0;
            arready  <= 1'b1;
            rd_state <= bench_ctrl_pkg::RD_IDLE;
            // only a completed read of a cycle register moves its toggle
            if (rd_idx == bench_ctrl_pkg::REG_DDR_CYCLES) begin
              ddr_upper <= !ddr_upper;
            end
            if (rd_idx == bench_ctrl_pkg::REG_DMA_CYCLES) begin
              dma_upper <= !dma_upper;
            end
          end
        end
        default: begin
          rd_state <= bench_ctrl_pkg::RD_IDLE;
        end
      endcase
    end
  end

  // read data holds while the host stalls
  a_rdata_stable: assert property (
    @(posedge user_clk) disable iff (!user_aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
  );

endmodule

`default_nettype wire

/* axil_write_front.sv */
// AXI-Lite write channel of the benchmark controller.
// Decodes the register index and hands each data word to the matching
// command builder, holding the write response until the builder acks.
`timescale 1ns/10ps
`default_nettype none

module axil_write_front (
  input  logic                                 user_clk,
  input  logic                                 user_aresetn,
  input  logic [bench_ctrl_pkg::AXIL_ADDR_W-1:0] awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] wdata,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic                                 bvalid,
  output logic [1:0]                           bresp,
  input  logic                                 bready,
  output logic                                 wr_word_valid,
  output logic [1:0]                           wr_word_sel,
  output logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] wr_word_data,
  input  logic                                 word_ack
);

  bench_ctrl_pkg::wr_state_e wr_state;

  logic [bench_ctrl_pkg::AXIL_ADDR_W-1:0] aw_shifted;
  logic [bench_ctrl_pkg::REG_IDX_W-1:0]   wr_idx; // latched at the aw transfer
  logic                                   w_fire;

  assign aw_shifted = awaddr >> bench_ctrl_pkg::REG_ADDR_SHIFT;
  assign w_fire     = (wr_state == bench_ctrl_pkg::WR_DATA) && wvalid && wready;

  // bit 0 selects the DDR builder, bit 1 the DMA builder
  always_comb begin
    case (wr_idx)
      bench_ctrl_pkg::REG_DDR_BENCH: wr_word_sel = 2'b01;
      bench_ctrl_pkg::REG_DMA_BENCH: wr_word_sel = 2'b10;
      default:                       wr_word_sel = 2'b00;
    endcase
  end

  assign wr_word_valid = w_fire && (wr_word_sel != 2'b00); // no strobe when unmapped
  assign wr_word_data  = wdata;
  assign bresp         = bench_ctrl_pkg::RESP_OKAY; // unmapped writes are just dropped

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      wr_state <= bench_ctrl_pkg::WR_IDLE;
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      case (wr_state)
        bench_ctrl_pkg::WR_IDLE: begin
          awready <= 1'b1;
          if (awvalid && awready) begin
            wr_idx   <= aw_shifted[bench_ctrl_pkg::REG_IDX_W-1:0];
            awready  <= 1'b0;
            wready   <= 1'b1;
            wr_state <= bench_ctrl_pkg::WR_DATA;
          end
        end
        bench_ctrl_pkg::WR_DATA: begin
          if (w_fire) begin
            wready <= 1'b0;
            if (wr_word_sel != 2'b00) begin
              wr_state <= bench_ctrl_pkg::WR_WAIT_ACK;
            end else begin
              wr_state <= bench_ctrl_pkg::WR_RESP; // bvalid follows next cycle
            end
          end
        end
        bench_ctrl_pkg::WR_WAIT_ACK: begin
          if (word_ack) begin
            bvalid   <= 1'b1;
            wr_state <= bench_ctrl_pkg::WR_RESP;
          end
        end
        bench_ctrl_pkg::WR_RESP: begin
          bvalid <= 1'b1;
          if (bvalid && bready) begin
            bvalid   <= 1'b0;
            awready  <= 1'b1; // ready again as soon as we are idle
            wr_state <= bench_ctrl_pkg::WR_IDLE;
          end
        end
        default: begin
          wr_state <= bench_ctrl_pkg::WR_IDLE;
        end
      endcase
    end
  end

  // a pending response is never withdrawn before the host takes it
  a_bvalid_hold: assert property (
    @(posedge user_clk) disable iff (!user_aresetn)
    bvalid && !bready |=> bvalid
  );

  // only one builder ever sees a given word
  a_sel_onehot: assert property (
    @(posedge user_clk) disable iff (!user_aresetn)
    wr_word_valid |-> $onehot(wr_word_sel)
  );

  // the builder ack only shows up while we are waiting for it
  a_ack_expected: assert property (
    @(posedge user_clk) disable iff (!user_aresetn)
    word_ack |-> wr_state == bench_ctrl_pkg::WR_WAIT_ACK
  );

endmodule

`default_nettype wire

/* bench_cmd_builder.sv */
// Collects eight host words into one benchmark command and offers it to
// an engine with valid/ready. Set HAS_DEST for engines that also take
// a destination field from word 7.
`timescale 1ns/10ps
`default_nettype none

module bench_cmd_builder #(
  parameter bit HAS_DEST = 1'b0
) (
  input  logic                                   user_clk,
  input  logic                                   user_aresetn,
  input  logic                                   word_valid,
  input  logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] word_data,
  output logic                                   word_ack,
  output logic                                   cmd_valid,
  input  logic                                   cmd_ready,
  output logic [bench_ctrl_pkg::CMD_W-1:0]       cmd_data,
  output logic [bench_ctrl_pkg::DEST_W-1:0]      cmd_dest
);

  localparam int CNT_W = $clog2(bench_ctrl_pkg::CMD_WORDS);
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(bench_ctrl_pkg::CMD_WORDS - 1);

  logic [CNT_W-1:0] word_cnt;
  logic             ack_q;    // ack for words 0 to 6
  logic             cmd_fire;

  assign cmd_fire = cmd_valid && cmd_ready;
  assign word_ack = ack_q || cmd_fire; // last word acked on acceptance

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      word_cnt  <= '0;
      ack_q     <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      ack_q <= word_valid && (word_cnt != LAST_WORD);
      if (word_valid) begin
        if (word_cnt == LAST_WORD) begin
          cmd_valid <= 1'b1; // counter holds until the command is taken
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
      if (cmd_fire) begin
        cmd_valid <= 1'b0;
        word_cnt  <= '0;
      end
    end
  end

  // field placement, see the layout in the package
  always_ff @(posedge user_clk) begin
    if (word_valid) begin
      case (word_cnt)
        3'd0: cmd_data[31:0]    <= word_data;
        3'd1: cmd_data[47:32]   <= word_data[15:0]; // base address high
        3'd2: cmd_data[79:48]   <= word_data;
        3'd3: cmd_data[95:80]   <= word_data[15:0]; // memory size high
        3'd4: cmd_data[127:96]  <= word_data;
        3'd5: cmd_data[159:128] <= word_data;
        3'd6: cmd_data[191:160] <= word_data;
        default: cmd_data[192]  <= word_data[0];
      endcase
    end
  end

  generate
    if (HAS_DEST) begin : g_dest
      always_ff @(posedge user_clk) begin
        if (word_valid && (word_cnt == LAST_WORD)) begin
          cmd_dest <= word_data[bench_ctrl_pkg::DEST_W:1];
        end
      end
    end else begin : g_no_dest
      assign cmd_dest = '0; // engine has a single target
    end
  endgenerate

  // engine sees a steady command until it takes it
  a_cmd_stable: assert property (
    @(posedge user_clk) disable iff (!user_aresetn)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data) && $stable(cmd_dest)
  );

  // the write front end holds off until the pending command is accepted
  a_no_word_while_busy: assert property (
    @(posedge user_clk) disable iff (!user_aresetn)
    cmd_valid |-> !word_valid
  );

endmodule

`default_nettype wire

/* bench_controller.sv */
// Register-mapped controller for the DDR and DMA memory benchmarks.
// The host builds commands through AXI-Lite writes and reads back the
// engines' execution-cycle counts. Single clock domain on user_clk.
`timescale 1ns/10ps
`default_nettype none

module bench_controller (
  input  logic                                   user_clk,
  input  logic                                   user_aresetn,

  input  logic [bench_ctrl_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
  input  logic                                   s_axil_awvalid,
  output logic                                   s_axil_awready,
  input  logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] s_axil_wdata,
  input  logic                                   s_axil_wvalid,
  output logic                                   s_axil_wready,
  output logic [1:0]                             s_axil_bresp,
  output logic                                   s_axil_bvalid,
  input  logic                                   s_axil_bready,
  input  logic [bench_ctrl_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
  input  logic                                   s_axil_arvalid,
  output logic                                   s_axil_arready,
  output logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] s_axil_rdata,
  output logic [1:0]                             s_axil_rresp,
  output logic                                   s_axil_rvalid,
  input  logic                                   s_axil_rready,

  output logic                                   ddr_cmd_valid,
  input  logic                                   ddr_cmd_ready,
  output logic [bench_ctrl_pkg::CMD_W-1:0]       ddr_cmd_data,
  output logic [bench_ctrl_pkg::DEST_W-1:0]      ddr_cmd_dest,

  output logic                                   dma_cmd_valid,
  input  logic                                   dma_cmd_ready,
  output logic [bench_ctrl_pkg::CMD_W-1:0]       dma_cmd_data,

  input  logic [bench_ctrl_pkg::CYCLES_W-1:0]    ddr_exec_cycles,
  input  logic [bench_ctrl_pkg::CYCLES_W-1:0]    dma_exec_cycles
);

  logic                                   wr_word_valid;
  logic [1:0]                             wr_word_sel;
  logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] wr_word_data;
  logic                                   ddr_word_ack;
  logic                                   dma_word_ack;

  axil_write_front write_front (
    .user_clk      (user_clk),
    .user_aresetn  (user_aresetn),
    .awaddr        (s_axil_awaddr),
    .awvalid       (s_axil_awvalid),
    .awready       (s_axil_awready),
    .wdata         (s_axil_wdata),
    .wvalid        (s_axil_wvalid),
    .wready        (s_axil_wready),
    .bvalid        (s_axil_bvalid),
    .bresp         (s_axil_bresp),
    .bready        (s_axil_bready),
    .wr_word_valid (wr_word_valid),
    .wr_word_sel   (wr_word_sel),
    .wr_word_data  (wr_word_data),
    .word_ack      (ddr_word_ack | dma_word_ack) // only one builder acks at a time
  );

  bench_cmd_builder #(.HAS_DEST(1'b1)) ddr_builder (
    .user_clk     (user_clk),
    .user_aresetn (user_aresetn),
    .word_valid   (wr_word_valid & wr_word_sel[0]),
    .word_data    (wr_word_data),
    .word_ack     (ddr_word_ack),
    .cmd_valid    (ddr_cmd_valid),
    .cmd_ready    (ddr_cmd_ready),
    .cmd_data     (ddr_cmd_data),
    .cmd_dest     (ddr_cmd_dest)
  );

  bench_cmd_builder #(.HAS_DEST(1'b0)) dma_builder (
    .user_clk     (user_clk),
    .user_aresetn (user_aresetn),
    .word_valid   (wr_word_valid & wr_word_sel[1]),
    .word_data    (wr_word_data),
    .word_ack     (dma_word_ack),
    .cmd_valid    (dma_cmd_valid),
    .cmd_ready    (dma_cmd_ready),
    .cmd_data     (dma_cmd_data),
    .cmd_dest     ()                // dma engine takes no destination
  );

  axil_cycle_reader cycle_reader (
    .user_clk        (user_clk),
    .user_aresetn    (user_aresetn),
    .araddr          (s_axil_araddr),
    .arvalid         (s_axil_arvalid),
    .arready         (s_axil_arready),
    .rvalid          (s_axil_rvalid),
    .rdata           (s_axil_rdata),
    .rresp           (s_axil_rresp),
    .rready          (s_axil_rready),
    .ddr_exec_cycles (ddr_exec_cycles),
    .dma_exec_cycles (dma_exec_cycles)
  );

endmodule

`default_nettype wire

/* bench_controller_tb.sv */
// Testbench for the benchmark controller. Drives random AXI-Lite traffic,
// keeps a model of both command images and of the read half toggles,
// and checks the command outputs and the read data against that model.
`timescale 1ns/10ps
`default_nettype none

module bench_controller_tb;

  localparam int TIMEOUT_CYCLES = 20000; // the tests need a few thousand cycles

  logic                                   user_clk = 1'b0;
  logic                                   user_aresetn;
  logic [bench_ctrl_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr;
  logic                                   s_axil_awvalid;
  logic                                   s_axil_awready;
  logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] s_axil_wdata;
  logic                                   s_axil_wvalid;
  logic                                   s_axil_wready;
  logic [1:0]                             s_axil_bresp;
  logic                                   s_axil_bvalid;
  logic                                   s_axil_bready;
  logic [bench_ctrl_pkg::AXIL_ADDR_W-1:0] s_axil_araddr;
  logic                                   s_axil_arvalid;
  logic                                   s_axil_arready;
  logic [bench_ctrl_pkg::AXIL_DATA_W-1:0] s_axil_rdata;
  logic [1:0]                             s_axil_rresp;
  logic                                   s_axil_rvalid;
  logic                                   s_axil_rready;
  logic                                   ddr_cmd_valid;
  logic                                   ddr_cmd_ready;
  logic [bench_ctrl_pkg::CMD_W-1:0]       ddr_cmd_data;
  logic [bench_ctrl_pkg::DEST_W-1:0]      ddr_cmd_dest;
  logic                                   dma_cmd_valid;
  logic                                   dma_cmd_ready;
  logic [bench_ctrl_pkg::CMD_W-1:0]       dma_cmd_data;
  logic [bench_ctrl_pkg::CYCLES_W-1:0]    ddr_exec_cycles;
  logic [bench_ctrl_pkg::CYCLES_W-1:0]    dma_exec_cycles;

  // reference model per builder (0 ddr, 1 dma)
  logic [bench_ctrl_pkg::CMD_W-1:0]  img [0:1];
  logic [bench_ctrl_pkg::DEST_W-1:0] ddr_dest_q;
  int                                word_cnt [0:1];
  bit                                pending [0:1];  // command complete and not yet taken
  int                                accepted [0:1];
  bit                                rd_upper [0:1]; // 0 ddr cycles, 1 dma cycles

  bit                                mon_en;
  bit                                dma_quiet;
  bit                                dma_hold;
  logic [bench_ctrl_pkg::CMD_W-1:0]  dma_data_q;
  int                                err_cnt;
  int                                chk_cnt;
  int                                cyc_cnt;
  integer                            seed = 32'h27a;
  integer                            ready_seed = 32'h27a; // own stream for ddr ready

  bench_controller uut (.*);

  always #2 user_clk = ~user_clk;

  function automatic int rand_delay(input int max);
    return {$random(seed)} % (max + 1);
  endfunction

  function automatic logic [7:0] unmapped_idx();
    logic [7:0] idx;
    do idx = 8'($random(seed));
    while (idx == 8'd2 || idx == 8'd3 || idx == 8'd13 || idx == 8'd14);
    return idx;
  endfunction

  task automatic expect_equal(input string name, input logic [255:0] exp,
                              input logic [255:0] act);
    chk_cnt++;
    assert (act === exp) else begin
      $display("Fail at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic expect_true(input bit cond, input string msg);
    chk_cnt++;
    assert (cond) else begin
      $display("error at %0t: %s", $time, msg);
      err_cnt++;
    end
  endtask

  // packs one host word into the model image of its builder
  task automatic store_word(input logic [7:0] idx, input logic [31:0] data);
    int b;
    if (idx == bench_ctrl_pkg::REG_DDR_BENCH) begin
      b = 0;
    end else if (idx == bench_ctrl_pkg::REG_DMA_BENCH) begin
      b = 1;
    end else begin
      return; // unmapped index leaves the model alone
    end
    case (word_cnt[b])
      0: img[b][31:0]    = data;
      1: img[b][47:32]   = data[15:0];
      2: img[b][79:48]   = data;
      3: img[b][95:80]   = data[15:0];
      4: img[b][127:96]  = data;
      5: img[b][159:128] = data;
      6: img[b][191:160] = data;
      default: begin
        img[b][192] = data[0];
        if (b == 0) begin
          ddr_dest_q = data[2:1];
        end
        pending[b] = 1'b1;
      end
    endcase
    word_cnt[b] = (word_cnt[b] + 1) % bench_ctrl_pkg::CMD_WORDS;
  endtask

  task automatic axil_write(input logic [7:0] idx, input logic [31:0] data);
    logic [1:0] resp;
    repeat (rand_delay(3)) @(posedge user_clk);
    @(posedge user_clk);
    s_axil_awaddr  <= 32'(idx) << bench_ctrl_pkg::REG_ADDR_SHIFT;
    s_axil_awvalid <= 1'b1;
    do @(negedge user_clk); while (!s_axil_awready);
    @(posedge user_clk);
    s_axil_awvalid <= 1'b0;
    repeat (rand_delay(3)) @(posedge user_clk);
    s_axil_wdata  <= data;
    s_axil_wvalid <= 1'b1;
    do @(negedge user_clk); while (!s_axil_wready);
    @(posedge user_clk); // w transfer on this edge
    s_axil_wvalid <= 1'b0;
    store_word(idx, data);
    repeat (rand_delay(3)) @(posedge user_clk);
    s_axil_bready <= 1'b1;
    do @(negedge user_clk); while (!s_axil_bvalid);
    resp = s_axil_bresp;
    @(posedge user_clk);
    s_axil_bready <= 1'b0;
    expect_equal("s_axil_bresp", bench_ctrl_pkg::RESP_OKAY, resp);
  endtask

  task automatic read_and_check(input logic [7:0] idx);
    logic [31:0] data;
    logic [1:0]  resp;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    repeat (rand_delay(3)) @(posedge user_clk);
    @(posedge user_clk);
    s_axil_araddr  <= 32'(idx) << bench_ctrl_pkg::REG_ADDR_SHIFT;
    s_axil_arvalid <= 1'b1;
    do @(negedge user_clk); while (!s_axil_arready);
    @(posedge user_clk);
    s_axil_arvalid <= 1'b0;
    repeat (rand_delay(3)) @(posedge user_clk);
    s_axil_rready <= 1'b1;
    do @(negedge user_clk); while (!s_axil_rvalid);
    data = s_axil_rdata;
    resp = s_axil_rresp;
    @(posedge user_clk);
    s_axil_rready <= 1'b0;
    exp_resp = bench_ctrl_pkg::RESP_OKAY;
    if (idx == bench_ctrl_pkg::REG_DDR_CYCLES) begin
      exp_data    = rd_upper[0] ? ddr_exec_cycles[63:32] : ddr_exec_cycles[31:0];
      rd_upper[0] = !rd_upper[0];
    end else if (idx == bench_ctrl_pkg::REG_DMA_CYCLES) begin
      exp_data    = rd_upper[1] ? dma_exec_cycles[63:32] : dma_exec_cycles[31:0];
      rd_upper[1] = !rd_upper[1];
    end else begin
      exp_data = bench_ctrl_pkg::BAD_READ_DATA;
      exp_resp = bench_ctrl_pkg::RESP_SLVERR;
    end
    expect_equal("s_axil_rdata", exp_data, data);
    expect_equal("s_axil_rresp", exp_resp, resp);
  endtask

  task automatic write_command(input logic [7:0] idx, input bit mix_unmapped);
    for (int w = 0; w < bench_ctrl_pkg::CMD_WORDS; w++) begin
      if (mix_unmapped && rand_delay(1) == 1) begin
        axil_write(unmapped_idx(), $random(seed));
      end
      axil_write(idx, $random(seed));
    end
  endtask

  // keeps dma ready low for a while after the command shows up
  task automatic release_dma_after(input int stall);
    do @(negedge user_clk); while (!dma_cmd_valid);
    repeat (stall) @(posedge user_clk);
    @(posedge user_clk);
    dma_cmd_ready <= 1'b1;
    @(posedge user_clk);
    dma_cmd_ready <= 1'b0;
  endtask

  task automatic check_idle_outputs();
    expect_true(!(s_axil_awready || s_axil_wready || s_axil_bvalid), "write channel active");
    expect_true(!(s_axil_arready || s_axil_rvalid), "read channel active");
    expect_true(!(ddr_cmd_valid || dma_cmd_valid), "command valid without a command");
    expect_true(!uut.wr_word_valid, "word strobe active");
  endtask

  task automatic finish_test(input int num, input string name, input int err_start);
    $display("test %0d %s finished, %0d errors", num, name, err_cnt - err_start);
  endtask

  always @(posedge user_clk) begin
    if (mon_en) begin
      ddr_cmd_ready <= 1'($random(ready_seed)); // random ddr back-pressure
    end
  end

  // command monitor samples on the falling edge
  always @(negedge user_clk) begin
    if (mon_en) begin
      expect_equal("ddr_cmd_valid", pending[0], ddr_cmd_valid);
      expect_equal("dma_cmd_valid", pending[1], dma_cmd_valid);
      if (ddr_cmd_valid) begin
        expect_equal("ddr_cmd_data", img[0], ddr_cmd_data);
        expect_equal("ddr_cmd_dest", ddr_dest_q, ddr_cmd_dest);
      end
      if (dma_cmd_valid) begin
        expect_equal("dma_cmd_data", img[1], dma_cmd_data);
      end
      if (dma_hold) begin
        expect_true(dma_cmd_valid, "dma_cmd_valid dropped before the engine took it");
        expect_equal("dma_cmd_data", dma_data_q, dma_cmd_data);
      end
      expect_true(!(s_axil_bvalid && (ddr_cmd_valid || dma_cmd_valid)),
                  "write response came before the engine took the command");
      if (dma_quiet) begin
        expect_true(!dma_cmd_valid, "dma command issued during a ddr test");
      end
      if (ddr_cmd_valid && ddr_cmd_ready) begin
        pending[0] = 1'b0;
        accepted[0]++;
      end
      if (dma_cmd_valid && dma_cmd_ready) begin
        pending[1] = 1'b0;
        accepted[1]++;
      end
      dma_hold   = dma_cmd_valid && !dma_cmd_ready;
      dma_data_q = dma_cmd_data;
    end
  end

  always @(posedge user_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles, a handshake never completed", cyc_cnt);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    int          err_start;
    int          stall;
    logic [31:0] last_word;
    user_aresetn    = 1'b0;
    s_axil_awaddr   = '0;
    s_axil_awvalid  = 1'b0;
    s_axil_wdata    = '0;
    s_axil_wvalid   = 1'b0;
    s_axil_bready   = 1'b0;
    s_axil_araddr   = '0;
    s_axil_arvalid  = 1'b0;
    s_axil_rready   = 1'b0;
    ddr_cmd_ready   = 1'b0;
    dma_cmd_ready   = 1'b0;
    ddr_exec_cycles = '0;
    dma_exec_cycles = '0;

    err_start = err_cnt;
    repeat (16) begin
      @(negedge user_clk);
      check_idle_outputs();
    end
    @(posedge user_clk);
    user_aresetn <= 1'b1;
    @(negedge user_clk);
    check_idle_outputs(); // awready still low one cycle after reset
    mon_en = 1'b1;
    finish_test(1, "reset state", err_start);

    err_start = err_cnt;
    dma_quiet = 1'b1;
    for (int c = 0; c < 4; c++) begin
      write_command(bench_ctrl_pkg::REG_DDR_BENCH, 1'b0);
    end
    dma_quiet = 1'b0;
    expect_equal("ddr commands accepted", 4, accepted[0]);
    finish_test(2, "ddr command assembly", err_start);

    err_start = err_cnt;
    for (int c = 0; c < 3; c++) begin
      for (int w = 0; w < bench_ctrl_pkg::CMD_WORDS - 1; w++) begin
        axil_write(bench_ctrl_pkg::REG_DMA_BENCH, $random(seed));
      end
      last_word = $random(seed);
      stall     = rand_delay(20) + 2;
      fork
        axil_write(bench_ctrl_pkg::REG_DMA_BENCH, last_word);
        release_dma_after(stall);
      join
    end
    expect_equal("dma commands accepted", 3, accepted[1]);
    finish_test(3, "dma back-pressure", err_start);

    err_start = err_cnt;
    axil_write(unmapped_idx(), $random(seed));
    for (int c = 0; c < 2; c++) begin
      write_command(bench_ctrl_pkg::REG_DDR_BENCH, 1'b1);
    end
    expect_equal("ddr commands accepted", 6, accepted[0]);
    finish_test(4, "unmapped writes", err_start);

    err_start = err_cnt;
    @(posedge user_clk);
    ddr_exec_cycles <= {$random(seed), $random(seed)};
    dma_exec_cycles <= {$random(seed), $random(seed)};
    for (int r = 0; r < 16; r++) begin
      read_and_check(rand_delay(1) ? bench_ctrl_pkg::REG_DMA_CYCLES
                                   : bench_ctrl_pkg::REG_DDR_CYCLES);
    end
    finish_test(5, "cycle-count reads", err_start);

    err_start = err_cnt;
    for (int r = 0; r < 16; r++) begin
      if (rand_delay(2) == 0) begin
        read_and_check(rand_delay(1) ? bench_ctrl_pkg::REG_DMA_CYCLES
                                     : bench_ctrl_pkg::REG_DDR_CYCLES);
      end else begin
        read_and_check(unmapped_idx());
      end
    end
    finish_test(6, "unmapped reads", err_start);

    $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench_ctrl_pkg.sv */
// Shared constants and types for the memory benchmark controller.
// Each design file refers to these by scoped name.
`default_nettype none

package bench_ctrl_pkg;

  localparam int AXIL_ADDR_W    = 32;
  localparam int AXIL_DATA_W    = 32;
  localparam int REG_ADDR_SHIFT = 5; // registers sit on 32-byte strides
  localparam int REG_IDX_W      = 8;

  // command layout, one host write per word
  //   word 0  base address low         -> cmd[31:0]
  //   word 1  base address high [15:0] -> cmd[47:32]
  //   word 2  memory size low          -> cmd[79:48]
  //   word 3  memory size high [15:0]  -> cmd[95:80]
  //   word 4  number of accesses       -> cmd[127:96]
  //   word 5  chunk length             -> cmd[159:128]
  //   word 6  stride                   -> cmd[191:160]
  //   word 7  bit 0 -> cmd[192], bits 2:1 -> destination (DDR only)
  localparam int CMD_W     = 193;
  localparam int CMD_WORDS = 8;
  localparam int DEST_W    = 2;
  localparam int CYCLES_W  = 64;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [AXIL_DATA_W-1:0] BAD_READ_DATA = 32'hdeadbeef;

  typedef enum logic [REG_IDX_W-1:0] {
    REG_DDR_BENCH  = 8'd2,
    REG_DMA_BENCH  = 8'd3,
    REG_DDR_CYCLES = 8'd13,
    REG_DMA_CYCLES = 8'd14
  } reg_idx_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_WAIT_ACK, // word handed to a builder, waiting for its ack
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

endpackage

`default_nettype wire

/* vlog.f */
bench_ctrl_pkg.sv
axil_write_front.sv
bench_cmd_builder.sv
axil_cycle_reader.sv
bench_controller.sv
bench_controller_tb.sv
